// File: sim/systolic_row_testdata.txt
# Run header: mode (0 exact, 1 DRUM) w0 w1 w2 pixel_count, then per pixel: clear_mask pixel
# Each run ends with expected acc0 acc1 acc2; all values hex; first value is the run count
7
# Exact mode with small values
0 03 05 07 4
0 01
0 02
0 03
0 04
1e 32 46
# Exact mode across the full range
0 ff 80 01 5
0 ff
0 10
0 a5
0 00
0 7e
22fce 11900 232
# DRUM mode where operands below 16 stay exact
1 03 0f 09 4
0 02
0 0f
0 07
0 0b
69 20d 13b
# DRUM mode with high leading ones
1 c8 0a 45 4
0 ff
0 31
0 06
0 9c
16720 1144 7c50
# Exact mode clearing element 1 at the third pixel
0 10 20 30 5
0 05
0 06
2 07
0 08
0 09
230 300 690
# Full-scale exact values that wrap the accumulator
0 ff ff ff 6
0 ff
0 ff
0 ff
2 ff
0 ff
0 ff
1f406 2fa03 1f406
# DRUM mode clearing element 1 at the third pixel
1 01 80 11 4
0 40
0 0f
2 e3
0 21
16b 9b40 1986

// File: src.f
+incdir+design
design/sa_pkg.sv
design/drum_encoder.sv
design/mac_pe.sv
design/systolic_row.sv
sim/tb_systolic_row.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the systolic row testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_systolic_row -Mdir obj_dir -f src.f \
    && ./obj_dir/Vtb_systolic_row \
    || { echo "Simulation failed"; exit 1; }

// File: sim/tb_systolic_row.sv
`timescale 1ns/10ps
`include "sa_defs.svh"

module tb_systolic_row;

    localparam string DATA_PATH = "sim/systolic_row_testdata.txt";

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_approx;
    sa_pkg::pixel_t             i_pixel;
    logic [`SA_N*`SA_WW-1:0]    i_weight;
    logic [`SA_N-1:0]           i_clear;
    logic [`SA_N*`SA_ACC_W-1:0] o_acc_result;
    logic [`SA_DW-1:0]          o_pass_pixel;
    logic [`SA_N*`SA_WW-1:0]    o_pass_weight;

    // Runs loaded from the data file
    logic                       mode_q[$];
    logic [`SA_N*`SA_WW-1:0]    weight_q[$];
    int                         count_q[$];
    logic [`SA_N-1:0]           clear_q[$];      // One mask per pixel
    sa_pkg::pixel_t             pixel_q[$];
    sa_pkg::acc_t               expect_q[$];     // SA_N values per run

    logic                       run_mode;
    logic [`SA_N*`SA_WW-1:0]    run_weight;
    logic [`SA_N*`SA_WW-1:0]    last_weight;     // Weight bus sampled at the last edge
    logic [`SA_DW-1:0]          word_hist[$];    // Words still inside the row
    int                         total_cycles;
    bit                         load_done;

    systolic_row u_systolic_row (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_approx      (i_approx),
        .i_pixel       (i_pixel),
        .i_weight      (i_weight),
        .i_clear       (i_clear),
        .o_acc_result  (o_acc_result),
        .o_pass_pixel  (o_pass_pixel),
        .o_pass_weight (o_pass_weight)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;              // 8 ns period
    end

    //////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [63:0] want,
                              input logic [63:0] got);
        $display("FAIL %s expected %0h got %0h", name, want, got);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic fail_plain(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Expected operand word
    //////////////////////////////////////////////////

    // Plain pixel in exact mode and shift with mantissa in DRUM mode
    function automatic logic [`SA_DW-1:0] encode_word(input logic approx,
                                                      input sa_pkg::pixel_t value);
        sa_pkg::operand_word_u word;
        int                    msb;
        int                    shift;
        word.plain = value;
        if (approx) begin
            word.pair.pad = '0;
            if (value[`SA_DW-1:`SA_MANT_W] == '0) begin
                word.pair.shamt = '0;           // Fits the mantissa as is
                word.pair.mant  = value[`SA_MANT_W-1:0];
            end else begin
                msb = `SA_DW - 1;
                while (!value[msb]) begin
                    msb--;
                end
                shift           = msb - (`SA_MANT_W - 1);
                word.pair.shamt = `SA_SHAMT_W'(shift);
                word.pair.mant  = `SA_MANT_W'(value >> shift) | `SA_MANT_W'(1);
            end
        end
        return word.plain;
    endfunction

    //////////////////////////////////////////////////
    // Data file
    //////////////////////////////////////////////////

    task automatic next_line(input int fd, output string line);
        string raw;
        int    rc;
        line = "";
        while (line.len() == 0) begin
            rc = $fgets(raw, fd);
            if (rc == 0) begin
                fail_plain("Test data file ended before all runs were read");
            end
            if (raw.len() > 1 && raw[0] != "#") begin
                line = raw;                     // Skips comments and blank lines
            end
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    rc;
        int    nruns;
        int    mode;
        int    npix;
        int    w0;
        int    w1;
        int    w2;
        int    clr;
        int    pix;
        int    e0;
        int    e1;
        int    e2;
        string line;
        fd = $fopen(DATA_PATH, "r");
        if (fd == 0) begin
            fail_plain("Cannot open the test data file");
        end
        next_line(fd, line);
        rc = $sscanf(line, "%h", nruns);
        if (rc != 1) begin
            fail_plain("Test data file does not start with a run count");
        end
        total_cycles = 16;                      // Reset phase
        for (int r = 0; r < nruns; r++) begin
            next_line(fd, line);
            rc = $sscanf(line, "%h %h %h %h %h", mode, w0, w1, w2, npix);
            if (rc != 5) begin
                fail_plain("Malformed run header in the test data file");
            end
            mode_q.push_back(mode[0]);
            weight_q.push_back({`SA_WW'(w2), `SA_WW'(w1), `SA_WW'(w0)});
            count_q.push_back(npix);
            for (int p = 0; p < npix; p++) begin
                next_line(fd, line);
                rc = $sscanf(line, "%h %h", clr, pix);
                if (rc != 2) begin
                    fail_plain("Malformed pixel line in the test data file");
                end
                clear_q.push_back(`SA_N'(clr));
                pixel_q.push_back(sa_pkg::pixel_t'(pix));
            end
            next_line(fd, line);
            rc = $sscanf(line, "%h %h %h", e0, e1, e2);
            if (rc != 3) begin
                fail_plain("Malformed expected values in the test data file");
            end
            expect_q.push_back(sa_pkg::acc_t'(e0));
            expect_q.push_back(sa_pkg::acc_t'(e1));
            expect_q.push_back(sa_pkg::acc_t'(e2));
            total_cycles += 1 + npix + `SA_N;   // Clear, pixels, flush
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////

    // Checks the pass registers and drives the next inputs at each clock
    task automatic drive_cycle(input logic [`SA_N-1:0] clear, input sa_pkg::pixel_t pixel);
        logic [`SA_DW-1:0] want_word;
        @(posedge i_clk);
        #1;
        want_word = word_hist.pop_front();      // Driven SA_N cycles ago
        assert (o_pass_pixel == want_word)
            else fail_value("o_pass_pixel", 64'(want_word), 64'(o_pass_pixel));
        assert (o_pass_weight == last_weight)
            else fail_value("o_pass_weight", 64'(last_weight), 64'(o_pass_weight));
        i_approx    = run_mode;
        i_weight    = run_weight;
        i_clear     = clear;
        i_pixel     = pixel;
        last_weight = run_weight;
        word_hist.push_back(encode_word(run_mode, pixel));
    endtask

    task automatic compare_accumulators(input int run);
        sa_pkg::acc_t got;
        sa_pkg::acc_t want;
        for (int n = 0; n < `SA_N; n++) begin
            got  = o_acc_result[n*`SA_ACC_W +: `SA_ACC_W];
            want = expect_q[run*`SA_N + n];
            assert (got == want)
                else fail_value($sformatf("o_acc_result[%0d]", n), 64'(want), 64'(got));
        end
    endtask

    initial begin
        int pix_idx;
        i_rst_n      = 1'b0;
        i_approx     = 1'b0;
        i_pixel      = '0;
        i_weight     = '0;
        i_clear      = '0;
        run_mode     = 1'b0;
        run_weight   = '0;
        last_weight  = '0;
        total_cycles = 0;
        load_done    = 1'b0;
        pix_idx      = 0;
        repeat (`SA_N) word_hist.push_back('0);  // Row is empty after reset
        load_testdata();
        load_done = 1'b1;

        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        assert (o_acc_result == '0)
            else fail_value("o_acc_result", 64'(0), 64'(o_acc_result));
        assert (o_pass_pixel == '0)
            else fail_value("o_pass_pixel", 64'(0), 64'(o_pass_pixel));
        assert (o_pass_weight == '0)
            else fail_value("o_pass_weight", 64'(0), 64'(o_pass_weight));

        for (int r = 0; r < mode_q.size(); r++) begin
            run_mode   = mode_q[r];
            run_weight = weight_q[r];
            drive_cycle('1, '0);                // Clear every element
            for (int p = 0; p < count_q[r]; p++) begin
                drive_cycle(clear_q[pix_idx], pixel_q[pix_idx]);
                pix_idx++;
            end
            repeat (`SA_N) drive_cycle('0, '0); // Flush the row
            compare_accumulators(r);
        end

        $display("TEST OK");
        $finish;
    end

    // Watchdog sized from the loaded runs
    initial begin
        wait (load_done);
        #((total_cycles + 100) * 8);
        fail_plain("Simulation timed out before all runs completed");
    end

endmodule

// File: design/systolic_row.sv
`timescale 1ns/10ps
`include "sa_defs.svh"

module systolic_row (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_approx,       // Static mode level
    input  sa_pkg::pixel_t                i_pixel,        // Enters element 0
    input  logic [`SA_N*`SA_WW-1:0]       i_weight,       // Element n at slice n
    input  logic [`SA_N-1:0]              i_clear,        // One strobe per element
    output logic [`SA_N*`SA_ACC_W-1:0]    o_acc_result,   // Element n at slice n
    output logic [`SA_DW-1:0]             o_pass_pixel,   // Word leaving the last element
    output logic [`SA_N*`SA_WW-1:0]       o_pass_weight   // Registered weight bus
);

    sa_pkg::drum_pair_t    pixel_pair;                    // Encoded entering pixel
    sa_pkg::operand_word_u entry_word;
    sa_pkg::operand_word_u operand_chain [`SA_N+1];       // Index n feeds element n

    //////////////////////////////////////////////////
    // Entering operand word
    //////////////////////////////////////////////////

    drum_encoder u_pixel_enc (
        .i_value (i_pixel),
        .o_pair  (pixel_pair)
    );

    always_comb begin
        entry_word.plain = i_pixel;
        if (i_approx) begin
            entry_word.pair = pixel_pair;   // Same bits read as a pair downstream
        end
    end

    assign operand_chain[0] = entry_word;

    //////////////////////////////////////////////////
    // Element chain
    //////////////////////////////////////////////////

    genvar n;
    generate
        for (n = 0; n < `SA_N; n++) begin : g_pe
            mac_pe u_mac_pe (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_approx   (i_approx),
                .i_operand  (operand_chain[n]),
                .i_weight   (i_weight[n*`SA_WW +: `SA_WW]),
                .i_clear    (i_clear[n]),
                .o_operand  (operand_chain[n+1]),
                .o_weight   (o_pass_weight[n*`SA_WW +: `SA_WW]),
                .o_acc      (o_acc_result[n*`SA_ACC_W +: `SA_ACC_W])
            );
        end
    endgenerate

    // N edges after entry
    assign o_pass_pixel = operand_chain[`SA_N].plain;

endmodule

// File: design/mac_pe.sv
`timescale 1ns/10ps
`include "sa_defs.svh"

module mac_pe (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_approx,     // High selects DRUM
    input  sa_pkg::operand_word_u i_operand,    // From the previous element
    input  sa_pkg::weight_t       i_weight,
    input  logic                  i_clear,      // Loads zero into the accumulator
    output sa_pkg::operand_word_u o_operand,    // To the next element
    output sa_pkg::weight_t       o_weight,     // Registered weight
    output sa_pkg::acc_t          o_acc
);

    localparam int PROD_W = `SA_DW + `SA_WW;

    sa_pkg::drum_pair_t         w_pair;         // Weight in DRUM form
    logic [2*`SA_MANT_W-1:0]    mant_prod;
    logic [`SA_SHAMT_W:0]       shift_sum;
    logic [PROD_W-1:0]          exact_prod;
    logic [PROD_W-1:0]          approx_prod;
    logic [PROD_W-1:0]          product;
    sa_pkg::acc_t               acc_q;

    drum_encoder u_weight_enc (
        .i_value (i_weight),
        .o_pair  (w_pair)
    );

    //////////////////////////////////////////////////
    // Two-mode multiplier
    //////////////////////////////////////////////////

    assign exact_prod = i_operand.plain * i_weight;

    // DRUM product is mantissa times mantissa scaled back up
    assign mant_prod = i_operand.pair.mant * w_pair.mant;
    assign shift_sum = {1'b0, i_operand.pair.shamt} + {1'b0, w_pair.shamt};

    assign approx_prod = {{(PROD_W - 2*`SA_MANT_W){1'b0}}, mant_prod} << shift_sum;

    assign product = i_approx ? approx_prod : exact_prod;

    //////////////////////////////////////////////////
    // Pass registers
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_operand <= '0;
            o_weight  <= '0;
        end else begin
            o_operand <= i_operand;     // One element per clock
            o_weight  <= i_weight;
        end
    end

    //////////////////////////////////////////////////
    // Accumulator
    //////////////////////////////////////////////////

    // Wraps modulo 2**SA_ACC_W
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (i_clear) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_q + {{(`SA_ACC_W - PROD_W){1'b0}}, product};
        end
    end

    assign o_acc = acc_q;

endmodule

// File: design/drum_encoder.sv
`timescale 1ns/10ps
`include "sa_defs.svh"

module drum_encoder (
    input  sa_pkg::pixel_t     i_value,        // Unsigned operand
    output sa_pkg::drum_pair_t o_pair          // Shift and mantissa
);

    logic [`SA_SHAMT_W-1:0] lead_pos;           // Position of the leading one
    logic [`SA_SHAMT_W-1:0] shamt;              // Bits dropped below the mantissa
    logic [`SA_DW-1:0]      shifted;            // Operand aligned to the mantissa

    // Priority scan where the highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < `SA_DW; i++) begin
            if (i_value[i]) begin
                lead_pos = `SA_SHAMT_W'(i);
            end
        end
    end

    assign shamt   = lead_pos - `SA_SHAMT_W'(`SA_MANT_W - 1);
    assign shifted = i_value >> shamt;

    always_comb begin
        o_pair.pad = '0;
        if (lead_pos < `SA_SHAMT_W'(`SA_MANT_W)) begin
            // Small values fit the mantissa as they are
            o_pair.shamt = '0;
            o_pair.mant  = i_value[`SA_MANT_W-1:0];
        end else begin
            o_pair.shamt = shamt;
            o_pair.mant  = {shifted[`SA_MANT_W-1:1], 1'b1};  // Unbiased rounding bit
        end
    end

endmodule

// File: design/sa_pkg.sv
`include "sa_defs.svh"

package sa_pkg;

    //////////////////////////////////////////////////
    // Data words of the row
    //////////////////////////////////////////////////

    typedef logic [`SA_DW-1:0]    pixel_t;      // One pixel
    typedef logic [`SA_WW-1:0]    weight_t;     // One weight
    typedef logic [`SA_ACC_W-1:0] acc_t;        // One accumulator

    // DRUM pair padded to a full pixel word
    typedef struct packed {
        logic [`SA_SHAMT_W-1:0]                     shamt;  // Leading one minus three
        logic [`SA_MANT_W-1:0]                      mant;   // Rounded top bits
        logic [`SA_DW-`SA_SHAMT_W-`SA_MANT_W-1:0]   pad;    // Always zero
    } drum_pair_t;

    //////////////////////////////////////////////////
    // Word moving along the row
    //////////////////////////////////////////////////

    // Read plain in exact mode and as a pair in DRUM mode
    typedef union packed {
        pixel_t     plain;
        drum_pair_t pair;
    } operand_word_u;

endpackage

// File: design/sa_defs.svh
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

// Row geometry
`define SA_N        3                   // Elements per row
`define SA_M        3                   // Rows in the full array

// Operand widths
`define SA_DW       8                   // Pixel width
`define SA_WW       8                   // Weight width

// Product width plus headroom for M partial sums down a column
`define SA_ACC_W    (`SA_DW + `SA_WW + $clog2(`SA_M))

// DRUM operand encoding
`define SA_MANT_W   4                   // Mantissa width
`define SA_SHAMT_W  3                   // Shift amount width

`endif
